// ==== dhi_macros.svh ====
`ifndef DHI_MACROS_SVH
`define DHI_MACROS_SVH

// Data path and LFSR width
`define DHI_XLEN 32

// Width of mcycle and minstret
`define DHI_CNT_W 64

// Galois feedback mask for x^32 + x^22 + x^2 + x + 1, applied on a right shift
`define DHI_LFSR_TAPS 32'h8020_0003

// Non-zero seeds that each LFSR returns to after reset or a lockup
`define DHI_LFSR0_SEED 32'hAC53_3BF4
`define DHI_LFSR1_SEED 32'h5F27_C1A9
`define DHI_LFSR2_SEED 32'hD1E2_0B73

// Width of the dummy frequency field
`define DHI_FREQ_W 4

// Lowest frequency setting of each interval band; anything below 8_MIN gives N = 4
`define DHI_FREQ_8_MIN 4'd1
`define DHI_FREQ_16_MIN 4'd2
`define DHI_FREQ_32_MIN 4'd4
`define DHI_FREQ_64_MIN 4'd8

// Gap counter width, large enough to hold the longest interval of 64
`define DHI_GAP_W 7

`endif

// ==== dhi_isa_pkg.sv ====
package dhi_isa_pkg;

  // One uncompressed RISC-V instruction word
  typedef logic [31:0] instr_t;

  // Index into the integer register file
  typedef logic [4:0] reg_addr_t;

  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // The four instruction kinds a dummy may take
  typedef enum logic [1:0] {
    DUMMY_ADD  = 2'b00,
    DUMMY_AND  = 2'b01,
    DUMMY_MUL  = 2'b10,
    DUMMY_BLTU = 2'b11
  } dummy_op_e;

  // Major opcodes, only the ones a dummy can use
  typedef enum logic [6:0] {
    OPCODE_OP     = 7'h33,
    OPCODE_BRANCH = 7'h63
  } opcode_e;

  // ADD and MUL share funct3 and differ in funct7
  localparam funct3_t FUNCT3_ADD  = 3'b000;
  localparam funct3_t FUNCT3_AND  = 3'b111;
  localparam funct3_t FUNCT3_MUL  = 3'b000;
  localparam funct3_t FUNCT3_BLTU = 3'b110;

  localparam funct7_t FUNCT7_ADD = 7'b000_0000;
  localparam funct7_t FUNCT7_AND = 7'b000_0000;
  localparam funct7_t FUNCT7_MUL = 7'b000_0001;

  // Hard-wired zero register
  localparam reg_addr_t REG_X0 = 5'd0;

endpackage

// ==== dhi_ctrl_pkg.sv ====
package dhi_ctrl_pkg;

  // Selects one LFSR on the CSR seed port
  // The encoding 2'd3 is unused and reads back as zero
  typedef enum logic [1:0] {
    LFSR0 = 2'd0,
    LFSR1 = 2'd1,
    LFSR2 = 2'd2
  } lfsr_sel_e;

  // Scheduler FSM
  // SCHED_COUNT counts real instructions until the gap runs out,
  // SCHED_INSERT waits for a ready slot to place the dummy
  typedef enum logic {
    SCHED_COUNT  = 1'b0,
    SCHED_INSERT = 1'b1
  } sched_state_e;

endpackage

// ==== dhi_lfsr_bank.sv ====
`timescale 1ns/1ps

`include "dhi_macros.svh"

module dhi_lfsr_bank (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     seed_we_i,
  input  dhi_ctrl_pkg::lfsr_sel_e  seed_sel_i,
  input  logic [`DHI_XLEN-1:0]     seed_wdata_i,
  input  logic                     adv0_i,
  input  logic                     adv12_i,
  output logic [`DHI_XLEN-1:0]     lfsr0_o,
  output logic [`DHI_XLEN-1:0]     lfsr1_o,
  output logic [`DHI_XLEN-1:0]     lfsr2_o,
  output logic [`DHI_XLEN-1:0]     seed_rdata_o
);

  localparam int NUM_LFSR = 3;

  localparam logic [NUM_LFSR-1:0][`DHI_XLEN-1:0] DEFAULT_SEED = {
    `DHI_LFSR2_SEED,
    `DHI_LFSR1_SEED,
    `DHI_LFSR0_SEED
  };

  logic [NUM_LFSR-1:0][`DHI_XLEN-1:0] lfsr_q;
  logic [NUM_LFSR-1:0]                adv;

  // LFSR1 and LFSR2 always step together for the operand pair
  assign adv = {adv12_i, adv12_i, adv0_i};

  for (genvar i = 0; i < NUM_LFSR; i++) begin : gen_lfsr
    logic                 seed_we;
    logic                 update;
    logic [`DHI_XLEN-1:0] lfsr_step;
    logic [`DHI_XLEN-1:0] lfsr_cand;
    logic [`DHI_XLEN-1:0] lfsr_d;

    assign seed_we = seed_we_i && (seed_sel_i == dhi_ctrl_pkg::lfsr_sel_e'(i));

    // Galois form: shift right and fold the tap mask in when bit 0 falls out
    assign lfsr_step = lfsr_q[i][0] ? ((lfsr_q[i] >> 1) ^ `DHI_LFSR_TAPS)
                                    : (lfsr_q[i] >> 1);

    // A CSR write wins, so an advance in the same cycle is lost
    assign lfsr_cand = seed_we ? seed_wdata_i : lfsr_step;
    assign update    = seed_we || adv[i];

    // An all-zero state would lock up, so fall back to the default seed
    assign lfsr_d = (lfsr_cand == '0) ? DEFAULT_SEED[i] : lfsr_cand;

    always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
        lfsr_q[i] <= DEFAULT_SEED[i];
      end else if (update) begin
        lfsr_q[i] <= lfsr_d;
      end
    end
  end

  assign lfsr0_o = lfsr_q[0];
  assign lfsr1_o = lfsr_q[1];
  assign lfsr2_o = lfsr_q[2];

  always_comb begin
    case (seed_sel_i)
      dhi_ctrl_pkg::LFSR0: seed_rdata_o = lfsr_q[0];
      dhi_ctrl_pkg::LFSR1: seed_rdata_o = lfsr_q[1];
      dhi_ctrl_pkg::LFSR2: seed_rdata_o = lfsr_q[2];
      default:             seed_rdata_o = '0;
    endcase
  end

endmodule

// ==== dhi_dummy_scheduler.sv ====
`timescale 1ns/1ps

`include "dhi_macros.svh"

module dhi_dummy_scheduler (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rnddummy_en_i,
  input  logic [`DHI_FREQ_W-1:0] rnddummyfreq_i,
  input  logic                   fetch_accept_i,
  input  logic                   id_ready_i,
  input  logic [`DHI_XLEN-1:0]   lfsr0_i,
  output logic                   insert_o,
  output logic                   adv0_o
);

  dhi_ctrl_pkg::sched_state_e state_q;
  logic [`DHI_GAP_W-1:0]      gap_q;
  logic                       gap_loaded_q;
  logic [`DHI_GAP_W-2:0]      gap_mask;
  logic [`DHI_GAP_W-1:0]      gap_reload;
  logic [`DHI_GAP_W-1:0]      gap_cur;

  // Interval N from the frequency field, expressed as the mask N-1
  always_comb begin
    if (rnddummyfreq_i >= `DHI_FREQ_64_MIN) begin
      gap_mask = 6'd63;
    end else if (rnddummyfreq_i >= `DHI_FREQ_32_MIN) begin
      gap_mask = 6'd31;
    end else if (rnddummyfreq_i >= `DHI_FREQ_16_MIN) begin
      gap_mask = 6'd15;
    end else if (rnddummyfreq_i >= `DHI_FREQ_8_MIN) begin
      gap_mask = 6'd7;
    end else begin
      gap_mask = 6'd3;
    end
  end

  // Random gap in the range 1 to N
  assign gap_reload = {1'b0, lfsr0_i[`DHI_GAP_W-2:0] & gap_mask} + `DHI_GAP_W'(1);

  // Right after enabling there is no gap yet, so the fresh one counts this cycle
  assign gap_cur = gap_loaded_q ? gap_q : gap_reload;

  // The dummy takes the slot only when ID can take it
  assign insert_o = (state_q == dhi_ctrl_pkg::SCHED_INSERT) && rnddummy_en_i && id_ready_i;
  assign adv0_o   = insert_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= dhi_ctrl_pkg::SCHED_COUNT;
      gap_q        <= '0;
      gap_loaded_q <= 1'b0;
    end else if (!rnddummy_en_i) begin
      // Start over with a new gap when insertion is turned back on
      state_q      <= dhi_ctrl_pkg::SCHED_COUNT;
      gap_loaded_q <= 1'b0;
    end else begin
      case (state_q)
        dhi_ctrl_pkg::SCHED_COUNT: begin
          gap_loaded_q <= 1'b1;
          if (fetch_accept_i) begin
            gap_q <= gap_cur - `DHI_GAP_W'(1);
            if (gap_cur == `DHI_GAP_W'(1)) begin
              state_q <= dhi_ctrl_pkg::SCHED_INSERT;
            end
          end else begin
            gap_q <= gap_cur;
          end
        end
        dhi_ctrl_pkg::SCHED_INSERT: begin
          if (insert_o) begin
            state_q <= dhi_ctrl_pkg::SCHED_COUNT;
            gap_q   <= gap_reload;
          end
        end
        default: begin
          state_q <= dhi_ctrl_pkg::SCHED_COUNT;
        end
      endcase
    end
  end

endmodule

// ==== dhi_dummy_encoder.sv ====
`timescale 1ns/1ps

`include "dhi_macros.svh"

module dhi_dummy_encoder (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 insert_i,
  input  logic                 fetch_accept_i,
  input  logic                 id_ready_i,
  input  dhi_isa_pkg::instr_t  fetch_instr_i,
  input  logic [`DHI_XLEN-1:0] lfsr0_i,
  input  logic [`DHI_XLEN-1:0] lfsr1_i,
  input  logic [`DHI_XLEN-1:0] lfsr2_i,
  output logic                 instr_valid_o,
  output dhi_isa_pkg::instr_t  instr_o,
  output logic                 instr_dummy_o,
  output logic [`DHI_XLEN-1:0] operand_a_o,
  output logic [`DHI_XLEN-1:0] operand_b_o,
  output logic                 adv12_o
);

  dhi_isa_pkg::dummy_op_e  dummy_op;
  dhi_isa_pkg::reg_addr_t  dummy_rs1;
  dhi_isa_pkg::reg_addr_t  dummy_rs2;
  dhi_isa_pkg::opcode_e    dummy_opcode;
  dhi_isa_pkg::funct3_t    dummy_funct3;
  dhi_isa_pkg::funct7_t    dummy_funct7;
  dhi_isa_pkg::instr_t     dummy_instr;
  logic [`DHI_XLEN-1:0]    dummy_op_a;
  logic [`DHI_XLEN-1:0]    dummy_op_b;
  logic                    load_en;

  // Top bits of LFSR0, clear of the low bits the scheduler uses for the gap
  assign dummy_op  = dhi_isa_pkg::dummy_op_e'(lfsr0_i[31:30]);
  assign dummy_rs1 = lfsr0_i[29:25];
  assign dummy_rs2 = lfsr0_i[24:20];

  always_comb begin
    dummy_opcode = dhi_isa_pkg::OPCODE_OP;
    dummy_funct7 = dhi_isa_pkg::FUNCT7_ADD;
    case (dummy_op)
      dhi_isa_pkg::DUMMY_ADD: begin
        dummy_funct3 = dhi_isa_pkg::FUNCT3_ADD;
      end
      dhi_isa_pkg::DUMMY_AND: begin
        dummy_funct3 = dhi_isa_pkg::FUNCT3_AND;
        dummy_funct7 = dhi_isa_pkg::FUNCT7_AND;
      end
      dhi_isa_pkg::DUMMY_MUL: begin
        dummy_funct3 = dhi_isa_pkg::FUNCT3_MUL;
        dummy_funct7 = dhi_isa_pkg::FUNCT7_MUL;
      end
      default: begin
        // BLTU with all immediate bits zero branches to itself
        dummy_opcode = dhi_isa_pkg::OPCODE_BRANCH;
        dummy_funct3 = dhi_isa_pkg::FUNCT3_BLTU;
        dummy_funct7 = '0;
      end
    endcase
  end

  // Bits 11:7 are rd for the R-type ops and imm[4:1|11] for BLTU, zero in both cases
  assign dummy_instr = {dummy_funct7, dummy_rs2, dummy_rs1, dummy_funct3,
                        dhi_isa_pkg::REG_X0, dummy_opcode};

  assign dummy_op_a = (dummy_rs1 == dhi_isa_pkg::REG_X0) ? '0 : lfsr1_i;
  assign dummy_op_b = (dummy_rs2 == dhi_isa_pkg::REG_X0) ? '0 : lfsr2_i;

  // Fresh operands for the next dummy once this one has been taken
  assign adv12_o = insert_i && id_ready_i;
  assign load_en = id_ready_i && (insert_i || fetch_accept_i);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      instr_valid_o <= 1'b0;
      instr_dummy_o <= 1'b0;
    end else if (id_ready_i) begin
      instr_valid_o <= insert_i || fetch_accept_i;
      instr_dummy_o <= insert_i;
    end
  end

  // Real instructions read their operands from the register file in ID
  always_ff @(posedge clk_i) begin
    if (load_en) begin
      instr_o     <= insert_i ? dummy_instr : fetch_instr_i;
      operand_a_o <= insert_i ? dummy_op_a : '0;
      operand_b_o <= insert_i ? dummy_op_b : '0;
    end
  end

endmodule

// ==== dhi_perf_counters.sv ====
`timescale 1ns/1ps

`include "dhi_macros.svh"

module dhi_perf_counters (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [2:0]            mcountinhibit_i,
  input  logic                  retire_i,
  input  logic                  retire_dummy_i,
  output logic [`DHI_CNT_W-1:0] mcycle_o,
  output logic [`DHI_CNT_W-1:0] minstret_o
);

  logic mcycle_en;
  logic minstret_en;

  // Bit 0 is CY and bit 2 is IR, as in mcountinhibit; bit 1 has no counter here
  assign mcycle_en   = !mcountinhibit_i[0];
  assign minstret_en = !mcountinhibit_i[2] && retire_i && !retire_dummy_i;

  // Both counters wrap silently at the top of their range
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mcycle_o <= '0;
    end else if (mcycle_en) begin
      mcycle_o <= mcycle_o + `DHI_CNT_W'(1);
    end
  end

  // Dummies still take a cycle, so they show in mcycle only
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      minstret_o <= '0;
    end else if (minstret_en) begin
      minstret_o <= minstret_o + `DHI_CNT_W'(1);
    end
  end

endmodule

// ==== dhi_top.sv ====
`timescale 1ns/1ps

`include "dhi_macros.svh"

module dhi_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     fetch_valid_i,
  input  dhi_isa_pkg::instr_t      fetch_instr_i,
  output logic                     fetch_ready_o,
  input  logic                     id_ready_i,
  output logic                     instr_valid_o,
  output dhi_isa_pkg::instr_t      instr_o,
  output logic                     instr_dummy_o,
  output logic [`DHI_XLEN-1:0]     operand_a_o,
  output logic [`DHI_XLEN-1:0]     operand_b_o,
  input  logic                     rnddummy_en_i,
  input  logic [`DHI_FREQ_W-1:0]   rnddummyfreq_i,
  input  logic                     seed_we_i,
  input  dhi_ctrl_pkg::lfsr_sel_e  seed_sel_i,
  input  logic [`DHI_XLEN-1:0]     seed_wdata_i,
  output logic [`DHI_XLEN-1:0]     seed_rdata_o,
  input  logic [2:0]               mcountinhibit_i,
  output logic [`DHI_CNT_W-1:0]    mcycle_o,
  output logic [`DHI_CNT_W-1:0]    minstret_o
);

  logic                 insert;
  logic                 fetch_accept;
  logic                 adv0;
  logic                 adv12;
  logic                 retire;
  logic [`DHI_XLEN-1:0] lfsr0;
  logic [`DHI_XLEN-1:0] lfsr1;
  logic [`DHI_XLEN-1:0] lfsr2;

  // A dummy takes the slot, so fetch stalls for that cycle
  assign fetch_ready_o = id_ready_i && !insert;
  assign fetch_accept  = fetch_valid_i && fetch_ready_o;

  // Anything leaving the IF/ID register retires in this model
  assign retire = instr_valid_o && id_ready_i;

  dhi_lfsr_bank u_lfsr_bank (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .seed_we_i    (seed_we_i),
    .seed_sel_i   (seed_sel_i),
    .seed_wdata_i (seed_wdata_i),
    .adv0_i       (adv0),
    .adv12_i      (adv12),
    .lfsr0_o      (lfsr0),
    .lfsr1_o      (lfsr1),
    .lfsr2_o      (lfsr2),
    .seed_rdata_o (seed_rdata_o)
  );

  dhi_dummy_scheduler u_scheduler (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rnddummy_en_i  (rnddummy_en_i),
    .rnddummyfreq_i (rnddummyfreq_i),
    .fetch_accept_i (fetch_accept),
    .id_ready_i     (id_ready_i),
    .lfsr0_i        (lfsr0),
    .insert_o       (insert),
    .adv0_o         (adv0)
  );

  dhi_dummy_encoder u_encoder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insert_i       (insert),
    .fetch_accept_i (fetch_accept),
    .id_ready_i     (id_ready_i),
    .fetch_instr_i  (fetch_instr_i),
    .lfsr0_i        (lfsr0),
    .lfsr1_i        (lfsr1),
    .lfsr2_i        (lfsr2),
    .instr_valid_o  (instr_valid_o),
    .instr_o        (instr_o),
    .instr_dummy_o  (instr_dummy_o),
    .operand_a_o    (operand_a_o),
    .operand_b_o    (operand_b_o),
    .adv12_o        (adv12)
  );

  dhi_perf_counters u_counters (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mcountinhibit_i (mcountinhibit_i),
    .retire_i        (retire),
    .retire_dummy_i  (instr_dummy_o),
    .mcycle_o        (mcycle_o),
    .minstret_o      (minstret_o)
  );

endmodule

// ==== tb_dhi_top.sv ====
`timescale 1ns/1ps

`include "dhi_macros.svh"

module tb_dhi_top;

  // The tests take about 4000 cycles, so this limit leaves a wide margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    fetch_valid_i;
  logic [31:0]             fetch_instr_i;
  logic                    fetch_ready_o;
  logic                    id_ready_i;
  logic                    instr_valid_o;
  logic [31:0]             instr_o;
  logic                    instr_dummy_o;
  logic [`DHI_XLEN-1:0]    operand_a_o;
  logic [`DHI_XLEN-1:0]    operand_b_o;
  logic                    rnddummy_en_i;
  logic [`DHI_FREQ_W-1:0]  rnddummyfreq_i;
  logic                    seed_we_i;
  dhi_ctrl_pkg::lfsr_sel_e seed_sel_i;
  logic [`DHI_XLEN-1:0]    seed_wdata_i;
  logic [`DHI_XLEN-1:0]    seed_rdata_o;
  logic [2:0]              mcountinhibit_i;
  logic [`DHI_CNT_W-1:0]   mcycle_o;
  logic [`DHI_CNT_W-1:0]   minstret_o;

  // Reference state of the three LFSRs and the expected output stream
  logic [31:0]     model_lfsr [3];
  logic [31:0]     default_seed [3];
  logic [31:0]     expected_q [$];
  string           test_name;
  int              cycles;
  int              edge_count;
  longint unsigned exp_minstret;
  bit              prev_ready;
  bit              prev_accept;
  logic            prev_valid;
  logic            prev_dummy;
  logic [31:0]     prev_instr;
  logic [31:0]     prev_op_a;
  logic [31:0]     prev_op_b;
  bit              check_runs;
  int              run_len;
  int              run_limit;
  int              dummy_count;
  int              op_seen [4];

  dhi_top dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_instr_i   (fetch_instr_i),
    .fetch_ready_o   (fetch_ready_o),
    .id_ready_i      (id_ready_i),
    .instr_valid_o   (instr_valid_o),
    .instr_o         (instr_o),
    .instr_dummy_o   (instr_dummy_o),
    .operand_a_o     (operand_a_o),
    .operand_b_o     (operand_b_o),
    .rnddummy_en_i   (rnddummy_en_i),
    .rnddummyfreq_i  (rnddummyfreq_i),
    .seed_we_i       (seed_we_i),
    .seed_sel_i      (seed_sel_i),
    .seed_wdata_i    (seed_wdata_i),
    .seed_rdata_o    (seed_rdata_o),
    .mcountinhibit_i (mcountinhibit_i),
    .mcycle_o        (mcycle_o),
    .minstret_o      (minstret_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    edge_count++;
    if (edge_count >= TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("mismatch in %s (%s): expected %h, actual %h",
                                  test_name, what, expected, actual));
    end
  endtask

  // One Galois step on a right shift; a zero result falls back to the default seed
  function automatic logic [31:0] lfsr_next(input logic [31:0] cur, input int idx);
    logic [31:0] nxt;
    nxt = cur[0] ? ((cur >> 1) ^ `DHI_LFSR_TAPS) : (cur >> 1);
    if (nxt == 32'h0) begin
      nxt = default_seed[idx];
    end
    return nxt;
  endfunction

  function automatic int interval_of(input int freq);
    if (freq == 0) begin
      return 4;
    end else if (freq == 1) begin
      return 8;
    end else if (freq <= 3) begin
      return 16;
    end else if (freq <= 7) begin
      return 32;
    end
    return 64;
  endfunction

  // Classifies a word as ADD (0), AND (1), MUL (2) or BLTU (3), or -1 for anything else
  function automatic int dummy_kind(input logic [31:0] w);
    if (w[6:0] == 7'h33 && w[14:12] == 3'b000 && w[31:25] == 7'h00) begin
      return 0;
    end else if (w[6:0] == 7'h33 && w[14:12] == 3'b111 && w[31:25] == 7'h00) begin
      return 1;
    end else if (w[6:0] == 7'h33 && w[14:12] == 3'b000 && w[31:25] == 7'h01) begin
      return 2;
    end else if (w[6:0] == 7'h63 && w[14:12] == 3'b110 && w[31:25] == 7'h00) begin
      return 3;
    end
    return -1;
  endfunction

  // Checks the outputs of one cycle and updates the reference state
  task automatic sample_outputs();
    bit          loaded;
    int          kind;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    logic [31:0] exp_instr;
    loaded = prev_ready && instr_valid_o;
    check_value("mcycle", cycles, mcycle_o);
    check_value("minstret", exp_minstret, minstret_o);
    check_value("fetch to ID latency", prev_accept, loaded && !instr_dummy_o);
    if (!id_ready_i || !rnddummy_en_i) begin
      check_value("fetch ready", id_ready_i, fetch_ready_o);
    end
    if (!prev_ready) begin
      check_value("valid held", prev_valid, instr_valid_o);
      check_value("dummy flag held", prev_dummy, instr_dummy_o);
      check_value("instruction held", prev_instr, instr_o);
      check_value("operand a held", prev_op_a, operand_a_o);
      check_value("operand b held", prev_op_b, operand_b_o);
    end else if (loaded && instr_dummy_o) begin
      kind = dummy_kind(instr_o);
      if (kind < 0) begin
        stop_with_failure($sformatf("%s: dummy word %h is not an ADD, AND, MUL or BLTU",
                                    test_name, instr_o));
      end
      op_seen[kind]++;
      check_value("dummy rd or branch offset", 5'd0, instr_o[11:7]);
      exp_a = (instr_o[19:15] == 5'd0) ? 32'h0 : model_lfsr[1];
      exp_b = (instr_o[24:20] == 5'd0) ? 32'h0 : model_lfsr[2];
      check_value("dummy operand a", exp_a, operand_a_o);
      check_value("dummy operand b", exp_b, operand_b_o);
      for (int i = 0; i < 3; i++) begin
        model_lfsr[i] = lfsr_next(model_lfsr[i], i);
      end
      dummy_count++;
      if (check_runs && (run_len < 1 || run_len > run_limit)) begin
        stop_with_failure($sformatf("%s: %0d real instructions between dummies, allowed 1 to %0d",
                                    test_name, run_len, run_limit));
      end
      run_len = 0;
    end else if (loaded) begin
      if (expected_q.size() == 0) begin
        stop_with_failure($sformatf("%s: an instruction came out that was never fetched",
                                    test_name));
      end
      exp_instr = expected_q.pop_front();
      check_value("real instruction", exp_instr, instr_o);
      run_len++;
    end
    check_value("LFSR read-back", model_lfsr[int'(seed_sel_i)], seed_rdata_o);

    if (fetch_valid_i && fetch_ready_o) begin
      expected_q.push_back(fetch_instr_i);
    end
    if (instr_valid_o && id_ready_i && !instr_dummy_o && !mcountinhibit_i[2]) begin
      exp_minstret++;
    end
    if (seed_we_i) begin
      model_lfsr[int'(seed_sel_i)] = (seed_wdata_i == 32'h0) ? default_seed[int'(seed_sel_i)]
                                                             : seed_wdata_i;
    end
    prev_ready  = id_ready_i;
    prev_accept = fetch_valid_i && fetch_ready_o;
    prev_valid  = instr_valid_o;
    prev_dummy  = instr_dummy_o;
    prev_instr  = instr_o;
    prev_op_a   = operand_a_o;
    prev_op_b   = operand_b_o;
  endtask

  // Inputs are set 1 ns after an edge, outputs are checked 1 ns later
  task automatic tick();
    bit count_cycle;
    #1;
    sample_outputs();
    // mcycle only counts edges where the CY inhibit bit is clear
    count_cycle = !mcountinhibit_i[0];
    @(posedge clk_i);
    #1;
    if (count_cycle) begin
      cycles++;
    end
  endtask

  task automatic stream_instrs(input int count, input int ready_pct);
    int sent;
    sent = 0;
    fetch_valid_i = 1'b1;
    fetch_instr_i = $urandom();
    while (sent < count) begin
      id_ready_i = ($urandom_range(99) < ready_pct);
      seed_sel_i = dhi_ctrl_pkg::lfsr_sel_e'($urandom_range(2));
      tick();
      if (prev_accept) begin
        sent++;
        fetch_instr_i = $urandom();
      end
    end
    fetch_valid_i = 1'b0;
  endtask

  task automatic drain();
    fetch_valid_i = 1'b0;
    id_ready_i    = 1'b1;
    while (expected_q.size() != 0) begin
      tick();
    end
    tick();
  endtask

  task automatic write_seed(input dhi_ctrl_pkg::lfsr_sel_e sel, input logic [31:0] value);
    seed_we_i    = 1'b1;
    seed_sel_i   = sel;
    seed_wdata_i = value;
    tick();
    seed_we_i = 1'b0;
    tick();
  endtask

  task automatic test_reset_disabled();
    test_name = "reset and disabled mode";
    for (int i = 0; i < 3; i++) begin
      seed_sel_i = dhi_ctrl_pkg::lfsr_sel_e'(i);
      tick();
      check_value("default seed", default_seed[i], seed_rdata_o);
    end
    rnddummy_en_i = 1'b0;
    dummy_count   = 0;
    stream_instrs(50, 100);
    drain();
    check_value("dummies while disabled", 0, dummy_count);
  endtask

  task automatic test_seeding();
    test_name = "seeding and lockup";
    write_seed(dhi_ctrl_pkg::LFSR1, 32'h1234_5678);
    check_value("written seed", 32'h1234_5678, seed_rdata_o);
    write_seed(dhi_ctrl_pkg::LFSR2, 32'h0);
    check_value("zero seed", `DHI_LFSR2_SEED, seed_rdata_o);
    write_seed(dhi_ctrl_pkg::LFSR0, $urandom() | 32'h1);
    write_seed(dhi_ctrl_pkg::LFSR1, $urandom() | 32'h1);
    write_seed(dhi_ctrl_pkg::LFSR2, $urandom() | 32'h1);
    // The monitor now follows every advance through the dummies
    rnddummyfreq_i = '0;
    rnddummy_en_i  = 1'b1;
    dummy_count    = 0;
    stream_instrs(60, 100);
    drain();
    rnddummy_en_i = 1'b0;
    tick();
    if (dummy_count == 0) begin
      stop_with_failure("seeding and lockup: no dummy was inserted");
    end
  endtask

  task automatic test_frequency();
    int settings [5] = '{0, 1, 3, 7, 15};
    foreach (settings[k]) begin
      test_name      = $sformatf("dummy frequency %0d", settings[k]);
      rnddummyfreq_i = settings[k];
      run_limit      = interval_of(settings[k]);
      rnddummy_en_i  = 1'b1;
      check_runs     = 1'b1;
      run_len        = 0;
      dummy_count    = 0;
      stream_instrs(400, 100);
      drain();
      if (run_len > run_limit) begin
        stop_with_failure($sformatf("%s: trailing run of %0d exceeds %0d",
                                    test_name, run_len, run_limit));
      end
      if (dummy_count == 0) begin
        stop_with_failure($sformatf("%s: no dummy was inserted", test_name));
      end
      check_runs    = 1'b0;
      rnddummy_en_i = 1'b0;
      tick();
    end
  endtask

  task automatic test_encoding();
    test_name = "dummy encoding";
    for (int k = 0; k < 4; k++) begin
      op_seen[k] = 0;
    end
    rnddummyfreq_i = '0;
    rnddummy_en_i  = 1'b1;
    stream_instrs(300, 100);
    drain();
    rnddummy_en_i = 1'b0;
    tick();
    for (int k = 0; k < 4; k++) begin
      if (op_seen[k] == 0) begin
        stop_with_failure($sformatf("dummy encoding: dummy kind %0d never appeared", k));
      end
    end
  endtask

  task automatic test_counters();
    logic [63:0] frozen;
    test_name      = "counters and back-pressure";
    rnddummyfreq_i = 4'd1;
    rnddummy_en_i  = 1'b1;
    stream_instrs(200, 60);
    mcountinhibit_i = 3'b100;
    frozen = minstret_o;
    stream_instrs(100, 60);
    check_value("minstret frozen", frozen, minstret_o);
    mcountinhibit_i = 3'b001;
    frozen = mcycle_o;
    stream_instrs(50, 60);
    check_value("mcycle frozen", frozen, mcycle_o);
    mcountinhibit_i = 3'b000;
    stream_instrs(100, 60);
    drain();
    rnddummy_en_i = 1'b0;
    tick();
  endtask

  initial begin
    void'($urandom(32'h47d28503));
    rst_ni          = 1'b0;
    fetch_valid_i   = 1'b0;
    fetch_instr_i   = '0;
    id_ready_i      = 1'b1;
    rnddummy_en_i   = 1'b0;
    rnddummyfreq_i  = '0;
    seed_we_i       = 1'b0;
    seed_sel_i      = dhi_ctrl_pkg::LFSR0;
    seed_wdata_i    = '0;
    mcountinhibit_i = '0;
    default_seed[0] = `DHI_LFSR0_SEED;
    default_seed[1] = `DHI_LFSR1_SEED;
    default_seed[2] = `DHI_LFSR2_SEED;
    for (int i = 0; i < 3; i++) begin
      model_lfsr[i] = default_seed[i];
    end
    cycles       = 0;
    edge_count   = 0;
    exp_minstret = 0;
    prev_ready   = 1'b1;
    prev_accept  = 1'b0;
    check_runs   = 1'b0;
    run_len      = 0;
    dummy_count  = 0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_reset_disabled();
    test_seeding();
    test_frequency();
    test_encoding();
    test_counters();

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
dhi_isa_pkg.sv
dhi_ctrl_pkg.sv
dhi_lfsr_bank.sv
dhi_dummy_scheduler.sv
dhi_dummy_encoder.sv
dhi_perf_counters.sv
dhi_top.sv
tb_dhi_top.sv

// ==== Bender.yml ====
package:
  name: dhi

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dhi_isa_pkg.sv
      - dhi_ctrl_pkg.sv
      - dhi_lfsr_bank.sv
      - dhi_dummy_scheduler.sv
      - dhi_dummy_encoder.sv
      - dhi_perf_counters.sv
      - dhi_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dhi_top.sv
